// File: xosera_main.f
design/xosera_pkg.sv
design/bus_reg_interface.sv
design/vram_arb.sv
design/video_gen.sv
design/color_out.sv
design/xosera_main.sv
test/tb_xosera_main.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and decide pass/fail from the log.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_xosera_main \
        -f xosera_main.f -o sim_tb_xosera_main; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_tb_xosera_main > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi

if ! grep -q "test passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0

// File: test/tb_xosera_main.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the display controller top; host bus rows from a table,
// shadow vram and palette as the pixel model, frame timing monitor and
// interrupt checks, one result line per test then the totals
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_xosera_main import xosera_pkg::*; ();
timeunit 1ns;
timeprecision 1ps;

localparam int FRAME_CYC  = DEF_H_TOTAL * DEF_V_TOTAL;            // 960 clocks
localparam int MAX_CYCLES = 2000 + 6 * FRAME_CYC;    // ~1300 bus clocks + 5 frame waits
localparam int LINE_WORDS = DEF_H_VISIBLE / PIX_PER_WORD;
localparam int NUM_PIX    = DEF_H_VISIBLE * DEF_V_VISIBLE;

typedef enum logic [1:0] {OP_WR, OP_RD, OP_VBL} op_t;
typedef struct {
    op_t        op;
    reg_num_t   rnum;
    logic       bsel;
    byte_t      data;
    int         exp;        // read byte, or bus_intr_o pulses per frame
} row_t;

logic clk = 1'b0;
logic reset_i, bus_cs_n_i, bus_rd_nwr_i, bus_bytesel_i;
reg_num_t bus_reg_num_i;
byte_t bus_data_i, bus_data_o;
logic bus_intr_o, hsync_o, vsync_o, dv_de_o;
logic [3:0] red_o, green_o, blue_o;
logic [11:0] rgb;

row_t rows[$];
word_t vram_shadow [LINE_WORDS * DEF_V_VISIBLE];
rgb_t pal_shadow [16];
int errors, pix_errs, tim_errs, pass_cnt, fail_cnt, cycles, seed_val;
int frames, frames_checked, intr_cnt, pix_cnt, hs_cnt, de_run, de_lines;
logic mon_on, pix_on, frame_ok, hs_prev, de_prev, vs_prev;

assign rgb = {red_o, green_o, blue_o};

xosera_main i_dut (
    .clk(clk), .reset_i(reset_i), .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i),
    .bus_reg_num_i(bus_reg_num_i), .bus_bytesel_i(bus_bytesel_i), .bus_data_i(bus_data_i),
    .bus_data_o(bus_data_o), .bus_intr_o(bus_intr_o), .red_o(red_o), .green_o(green_o),
    .blue_o(blue_o), .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
);

always #50 clk = ~clk;      // 100 ns period

// watchdog
always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
        $display("timeout: run still busy after %0d clock cycles", MAX_CYCLES);
        $display("test failed");
        $finish;
    end
end

// expected colour, line y pixel x from word y*8 + x/4, msb nibble first
function automatic rgb_t pixel_rgb(input int line, input int x);
    word_t  w;
    color_t nib;
    w   = vram_shadow[(line * LINE_WORDS + x / PIX_PER_WORD) % (LINE_WORDS * DEF_V_VISIBLE)];
    nib = color_t'(w >> (12 - 4 * (x % PIX_PER_WORD)));
    return pal_shadow[nib];
endfunction

// video monitor, samples on the falling edge
always @(negedge clk) begin
    if (mon_on) begin
        if (bus_intr_o) intr_cnt++;
        if (!dv_de_o && rgb !== 12'h000) begin
            $display("error %0t: rgb %h while display enable low", $time, rgb);
            tim_errs++;
        end
        if (hsync_o && !hs_prev) hs_cnt++;             // hsync rising
        if (dv_de_o) begin
            if (pix_on) begin
                if (rgb !== pixel_rgb(de_lines, de_run)) begin
                    $display("error %0t: pixel %0d,%0d is %h, expected %h", $time,
                             de_run, de_lines, rgb, pixel_rgb(de_lines, de_run));
                    pix_errs++;
                end
                pix_cnt++;
            end
            de_run++;
        end else if (de_prev) begin                 // end of a visible line
            if (de_run != DEF_H_VISIBLE) begin
                $display("error %0t: line with %0d enable cycles", $time, de_run);
                tim_errs++;
            end
            de_lines++;
            de_run = 0;
        end
        if (!vsync_o && vs_prev) begin              // frame boundary
            if (frame_ok) begin
                if (hs_cnt != DEF_V_TOTAL || de_lines != DEF_V_VISIBLE) begin
                    $display("error %0t: frame had %0d hsyncs, %0d visible lines",
                             $time, hs_cnt, de_lines);
                    tim_errs++;
                end
                frames_checked++;
            end
            frame_ok = 1'b1;
            hs_cnt   = 0;
            de_lines = 0;
            frames++;
        end
        hs_prev = hsync_o;
        de_prev = dv_de_o;
        vs_prev = vsync_o;
    end
end

// one host byte access, driven on the falling edge
task automatic bus_access(input logic rd, input reg_num_t rnum, input logic bsel,
                          input byte_t data, output byte_t q);
    @(negedge clk);
    bus_cs_n_i    = 1'b0;
    bus_rd_nwr_i  = rd;
    bus_reg_num_i = rnum;
    bus_bytesel_i = bsel;
    bus_data_i    = data;
    @(negedge clk);
    bus_cs_n_i   = 1'b1;
    bus_rd_nwr_i = 1'b1;
    q = bus_data_o;             // registered on the edge in between
endtask

task automatic wait_frames(input int n);
    int target;
    @(posedge clk);             // away from the monitor edge
    target = frames + n;
    while (frames < target) @(posedge clk);
endtask

task automatic add_row(input op_t op, input reg_num_t rnum, input logic bsel,
                       input byte_t data, input int exp);
    rows.push_back('{op, rnum, bsel, data, exp});
endtask

task automatic run_rows();
    row_t  r;
    byte_t q;
    int    n0;
    foreach (rows[i]) begin
        r = rows[i];
        case (r.op)
            OP_WR: begin
                bus_access(1'b0, r.rnum, r.bsel, r.data, q);
                if (r.bsel && (r.rnum == REG_DATA || r.rnum == REG_RD_ADDR)) begin
                    repeat (6) @(negedge clk);      // vram access settles
                end
            end
            OP_RD: begin
                bus_access(1'b1, r.rnum, r.bsel, 8'h00, q);
                if (q !== byte_t'(r.exp)) begin
                    $display("error %0t: reg %0d byte %0d read %h, expected %h",
                             $time, r.rnum, r.bsel, q, byte_t'(r.exp));
                    errors++;
                end
            end
            default: begin
                n0 = intr_cnt;
                wait_frames(1);
                if (intr_cnt - n0 != r.exp) begin
                    $display("error %0t: %0d interrupt pulses in a frame, expected %0d",
                             $time, intr_cnt - n0, r.exp);
                    errors++;
                end
            end
        endcase
    end
    rows.delete();
endtask

task automatic report_test(input string name, input int err_before);
    if (errors + pix_errs + tim_errs == err_before) begin
        pass_cnt++;
        $display("%s: ok", name);
    end else begin
        fail_cnt++;
        $display("%s: FAIL", name);
    end
endtask

task automatic check_reset_outputs();
    if ({bus_intr_o, dv_de_o, hsync_o, vsync_o} !== 4'b0 || rgb !== 12'h0
        || bus_data_o !== 8'h00) begin
        $display("error %0t: outputs not low around reset", $time);
        errors++;
    end
endtask

initial begin
    int    e0;
    word_t w;
    rgb_t  p;
    int    a;
    seed_val = $urandom(32'h8fcb);
    {errors, pix_errs, tim_errs, pass_cnt, fail_cnt, cycles} = '0;
    {frames, frames_checked, intr_cnt, pix_cnt, hs_cnt, de_run, de_lines} = '0;
    {mon_on, pix_on, frame_ok, hs_prev, de_prev, vs_prev} = '0;
    reset_i       = 1'b1;
    bus_cs_n_i    = 1'b1;
    bus_rd_nwr_i  = 1'b1;
    bus_reg_num_i = '0;
    bus_bytesel_i = 1'b0;
    bus_data_i    = '0;

    // 1: reset held 4 cycles, then 2 more
    e0 = 0;
    repeat (4) begin
        @(negedge clk);
        check_reset_outputs();
    end
    reset_i = 1'b0;
    mon_on  = 1'b1;
    repeat (2) begin
        @(negedge clk);
        check_reset_outputs();
    end
    report_test("reset", e0);

    // 2: 128 words with auto-increment, then random read-back
    e0 = errors + pix_errs + tim_errs;
    add_row(OP_WR, REG_WR_ADDR, 1'b1, 8'h00, 0);
    for (int i = 0; i < LINE_WORDS * DEF_V_VISIBLE; i++) begin
        w = word_t'($urandom);
        vram_shadow[i] = w;
        add_row(OP_WR, REG_DATA, 1'b0, w[15:8], 0);
        add_row(OP_WR, REG_DATA, 1'b1, w[7:0], 0);
    end
    for (int i = 0; i < 16; i++) begin
        a = $urandom % (LINE_WORDS * DEF_V_VISIBLE);
        add_row(OP_WR, REG_RD_ADDR, 1'b1, byte_t'(a), 0);
        add_row(OP_RD, REG_DATA, 1'b0, 8'h00, vram_shadow[a][15:8]);
        add_row(OP_RD, REG_DATA, 1'b1, 8'h00, vram_shadow[a][7:0]);
    end
    run_rows();
    report_test("vram write and read-back", e0);

    // 3: palette load, then one whole frame of pixels
    e0 = errors + pix_errs + tim_errs;
    add_row(OP_WR, REG_PAL_ADDR, 1'b1, 8'h00, 0);
    for (int i = 0; i < 16; i++) begin
        p = rgb_t'($urandom);
        pal_shadow[i] = p;
        add_row(OP_WR, REG_PAL_DATA, 1'b0, {4'h0, p[11:8]}, 0);
        add_row(OP_WR, REG_PAL_DATA, 1'b1, p[7:0], 0);
    end
    run_rows();
    wait_frames(1);
    pix_on = 1'b1;
    wait_frames(1);
    pix_on = 1'b0;
    if (pix_cnt != NUM_PIX) begin
        $display("pixel check covered %0d pixels instead of %0d", pix_cnt, NUM_PIX);
        errors++;
    end
    report_test("palette and pixels", e0);

    // 4: frame counts come from the monitor, same frames as above
    e0 = errors + pix_errs;
    if (frames_checked == 0) begin
        $display("no complete frame was seen by the monitor");
        errors++;
    end
    report_test("timing counts", e0);

    // 5: clear pending, masked vblank, mask set, pending blocks the next one
    e0 = errors + pix_errs + tim_errs;
    add_row(OP_WR,  REG_INT_CTRL, 1'b1, 8'h01, 0);
    add_row(OP_VBL, REG_INT_CTRL, 1'b0, 8'h00, 0);
    add_row(OP_RD,  REG_INT_CTRL, 1'b1, 8'h00, 1);
    add_row(OP_RD,  REG_INT_CTRL, 1'b0, 8'h00, 0);
    add_row(OP_WR,  REG_INT_CTRL, 1'b1, 8'h01, 0);
    add_row(OP_RD,  REG_INT_CTRL, 1'b1, 8'h00, 0);
    add_row(OP_WR,  REG_INT_CTRL, 1'b0, 8'h01, 0);
    add_row(OP_RD,  REG_INT_CTRL, 1'b0, 8'h00, 1);
    add_row(OP_VBL, REG_INT_CTRL, 1'b0, 8'h00, 1);
    add_row(OP_VBL, REG_INT_CTRL, 1'b0, 8'h00, 0);
    add_row(OP_RD,  REG_INT_CTRL, 1'b1, 8'h00, 1);
    add_row(OP_WR,  REG_INT_CTRL, 1'b1, 8'h01, 0);
    add_row(OP_RD,  REG_INT_CTRL, 1'b1, 8'h00, 0);
    run_rows();
    report_test("interrupts", e0);

    $display("tests %0d, ok %0d, failing %0d, check errors %0d", pass_cnt + fail_cnt,
             pass_cnt, fail_cnt, errors + pix_errs + tim_errs);
    if (errors + pix_errs + tim_errs == 0 && fail_cnt == 0) begin
        $display("test passed");
    end else begin
        $display("test failed");
    end
    $finish;
end

endmodule

// File: design/xosera_main.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top of the display controller; host register interface, vram arbiter,
// video generator and palette output stage wired together, video timing
// set by the parameters below
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module xosera_main import xosera_pkg::*; #(
    parameter int H_VISIBLE    = DEF_H_VISIBLE,
    parameter int H_TOTAL      = DEF_H_TOTAL,
    parameter int H_SYNC_START = DEF_H_SYNC_START,
    parameter int H_SYNC_END   = DEF_H_SYNC_END,
    parameter int V_VISIBLE    = DEF_V_VISIBLE,
    parameter int V_TOTAL      = DEF_V_TOTAL,
    parameter int V_SYNC_START = DEF_V_SYNC_START,
    parameter int V_SYNC_END   = DEF_V_SYNC_END
) (
    input  wire logic       clk,            // pixel clock
    input  wire logic       reset_i,
    input  wire logic       bus_cs_n_i,
    input  wire logic       bus_rd_nwr_i,
    input  wire reg_num_t   bus_reg_num_i,
    input  wire logic       bus_bytesel_i,
    input  wire byte_t      bus_data_i,
    output byte_t           bus_data_o,
    output logic            bus_intr_o,     // cpu interrupt strobe
    output logic [3:0]      red_o,
    output logic [3:0]      green_o,
    output logic [3:0]      blue_o,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            dv_de_o         // display enable
);

word_t  vram_data;          // shared vram read data
logic   vgen_sel;
addr_t  vgen_addr;
logic   regs_sel;
logic   regs_wr;
logic   regs_ack;
addr_t  regs_addr;
word_t  regs_data;
logic   pal_wr;
color_t pal_addr;
rgb_t   pal_data;
color_t vgen_index;
logic   vgen_de;
logic   vgen_hsync;
logic   vgen_vsync;
logic   vblank_intr;

bus_reg_interface i_regs (
    .clk            (clk),
    .reset_i        (reset_i),
    .bus_cs_n_i     (bus_cs_n_i),
    .bus_rd_nwr_i   (bus_rd_nwr_i),
    .bus_reg_num_i  (bus_reg_num_i),
    .bus_bytesel_i  (bus_bytesel_i),
    .bus_data_i     (bus_data_i),
    .bus_data_o     (bus_data_o),
    .regs_ack_i     (regs_ack),
    .vram_data_i    (vram_data),
    .vblank_intr_i  (vblank_intr),
    .regs_sel_o     (regs_sel),
    .regs_wr_o      (regs_wr),
    .regs_addr_o    (regs_addr),
    .regs_data_o    (regs_data),
    .pal_wr_o       (pal_wr),
    .pal_addr_o     (pal_addr),
    .pal_data_o     (pal_data),
    .bus_intr_o     (bus_intr_o)
);

vram_arb i_vram (
    .clk            (clk),
    .vgen_sel_i     (vgen_sel),
    .vgen_addr_i    (vgen_addr),
    .regs_sel_i     (regs_sel),
    .regs_wr_i      (regs_wr),
    .regs_addr_i    (regs_addr),
    .regs_data_i    (regs_data),
    .regs_ack_o     (regs_ack),
    .vram_data_o    (vram_data)
);

video_gen #(
    .H_VISIBLE      (H_VISIBLE),
    .H_TOTAL        (H_TOTAL),
    .H_SYNC_START   (H_SYNC_START),
    .H_SYNC_END     (H_SYNC_END),
    .V_VISIBLE      (V_VISIBLE),
    .V_TOTAL        (V_TOTAL),
    .V_SYNC_START   (V_SYNC_START),
    .V_SYNC_END     (V_SYNC_END)
) i_vgen (
    .clk            (clk),
    .reset_i        (reset_i),
    .vram_data_i    (vram_data),
    .vram_sel_o     (vgen_sel),
    .vram_addr_o    (vgen_addr),
    .vgen_index_o   (vgen_index),
    .vgen_de_o      (vgen_de),
    .vgen_hsync_o   (vgen_hsync),
    .vgen_vsync_o   (vgen_vsync),
    .vblank_intr_o  (vblank_intr)
);

color_out i_color (
    .clk            (clk),
    .reset_i        (reset_i),
    .pal_wr_i       (pal_wr),
    .pal_addr_i     (pal_addr),
    .pal_data_i     (pal_data),
    .index_i        (vgen_index),
    .de_i           (vgen_de),
    .hsync_i        (vgen_hsync),
    .vsync_i        (vgen_vsync),
    .red_o          (red_o),
    .green_o        (green_o),
    .blue_o         (blue_o),
    .hsync_o        (hsync_o),
    .vsync_o        (vsync_o),
    .dv_de_o        (dv_de_o)
);

endmodule

// File: design/color_out.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// output stage; 16 entry palette lookup then output register, syncs and
// display enable delayed the same two cycles, colour forced to black
// whenever display enable is low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module color_out import xosera_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire logic   pal_wr_i,       // palette write strobe
    input  wire color_t pal_addr_i,
    input  wire rgb_t   pal_data_i,
    input  wire color_t index_i,
    input  wire logic   de_i,
    input  wire logic   hsync_i,
    input  wire logic   vsync_i,
    output logic [3:0]  red_o,
    output logic [3:0]  green_o,
    output logic [3:0]  blue_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        dv_de_o
);

rgb_t   pal_mem [16];
rgb_t   pal_rgb;        // lookup result, stage 1
logic   de_1;
logic   hsync_1;
logic   vsync_1;

always_ff @(posedge clk) begin
    if (pal_wr_i) begin
        pal_mem[pal_addr_i] <= pal_data_i;
    end
    pal_rgb <= pal_mem[index_i];
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        de_1    <= 1'b0;
        hsync_1 <= 1'b0;
        vsync_1 <= 1'b0;
        {red_o, green_o, blue_o} <= '0;
        hsync_o <= 1'b0;
        vsync_o <= 1'b0;
        dv_de_o <= 1'b0;
    end else begin
        de_1    <= de_i;        // lookup stage
        hsync_1 <= hsync_i;
        vsync_1 <= vsync_i;
        {red_o, green_o, blue_o} <= de_1 ? pal_rgb : 12'h000;     // blank
        hsync_o <= hsync_1;
        vsync_o <= vsync_1;
        dv_de_o <= de_1;
    end
end

endmodule

// File: design/video_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video timing and bitmap fetch; counts pixels and lines, reads one vram
// word per four pixels and shifts out 4-bit indices msb nibble first,
// with de and syncs delayed two cycles to line up with the pixels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module video_gen import xosera_pkg::*; #(
    parameter int H_VISIBLE    = DEF_H_VISIBLE,     // multiple of 4
    parameter int H_TOTAL      = DEF_H_TOTAL,
    parameter int H_SYNC_START = DEF_H_SYNC_START,
    parameter int H_SYNC_END   = DEF_H_SYNC_END,
    parameter int V_VISIBLE    = DEF_V_VISIBLE,
    parameter int V_TOTAL      = DEF_V_TOTAL,
    parameter int V_SYNC_START = DEF_V_SYNC_START,
    parameter int V_SYNC_END   = DEF_V_SYNC_END
) (
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire word_t  vram_data_i,
    output logic        vram_sel_o,
    output addr_t       vram_addr_o,
    output color_t      vgen_index_o,
    output logic        vgen_de_o,
    output logic        vgen_hsync_o,
    output logic        vgen_vsync_o,
    output logic        vblank_intr_o   // start of vertical blank
);

localparam int PIX_SHIFT = $clog2(PIX_PER_WORD);    // pixel to word index

hcount_t    h_count;
vcount_t    v_count;
logic       h_blank;        // right of visible area
logic       v_blank;        // below visible area
logic       de;
logic       hsync;
logic       vsync;
logic [1:0] de_dly;         // two stage delay, matches fetch pipe
logic [1:0] hs_dly;
logic [1:0] vs_dly;
logic       fetch_d;        // vram word valid on vram_data_i
word_t      pix_shift;      // current word, top nibble is the pixel

assign h_blank = (h_count >= hcount_t'(H_VISIBLE));
assign v_blank = (v_count >= vcount_t'(V_VISIBLE));
assign de      = ~h_blank & ~v_blank;
assign hsync   = (h_count >= hcount_t'(H_SYNC_START)) && (h_count < hcount_t'(H_SYNC_END));
assign vsync   = (v_count >= vcount_t'(V_SYNC_START)) && (v_count < vcount_t'(V_SYNC_END));

// fetch on first pixel of each group of four, word y*8 + x/4
assign vram_sel_o  = de && (h_count[PIX_SHIFT-1:0] == '0);
assign vram_addr_o = addr_t'(v_count << WORDS_PER_LINE_SHIFT) + addr_t'(h_count >> PIX_SHIFT);

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count <= '0;
        v_count <= '0;
    end else if (h_count == hcount_t'(H_TOTAL - 1)) begin
        h_count <= '0;
        if (v_count == vcount_t'(V_TOTAL - 1)) begin
            v_count <= '0;      // new frame
        end else begin
            v_count <= v_count + 1'b1;
        end
    end else begin
        h_count <= h_count + 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        de_dly        <= '0;
        hs_dly        <= '0;
        vs_dly        <= '0;
        fetch_d       <= 1'b0;
        vblank_intr_o <= 1'b0;
    end else begin
        de_dly  <= {de_dly[0], de};
        hs_dly  <= {hs_dly[0], hsync};
        vs_dly  <= {vs_dly[0], vsync};
        fetch_d <= vram_sel_o;
        // pulse as the line counter steps into V_VISIBLE
        vblank_intr_o <= (h_count == hcount_t'(H_TOTAL - 1)) &&
                         (v_count == vcount_t'(V_VISIBLE - 1));
    end
end

// load the fetched word, otherwise move up one pixel
always_ff @(posedge clk) begin
    if (fetch_d) begin
        pix_shift <= vram_data_i;
    end else begin
        pix_shift <= {pix_shift[11:0], 4'h0};
    end
end

assign vgen_index_o = pix_shift[15:12];
assign vgen_de_o    = de_dly[1];
assign vgen_hsync_o = hs_dly[1];
assign vgen_vsync_o = vs_dly[1];

endmodule

// File: design/vram_arb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 256 word video ram with one port shared by the video fetch and the cpu;
// video always wins, the cpu select is held until regs_ack_o pulses and
// read data is valid on vram_data_o the cycle after a grant
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module vram_arb import xosera_pkg::*; (
    input  wire logic   clk,
    input  wire logic   vgen_sel_i,     // video fetch, read only
    input  wire addr_t  vgen_addr_i,
    input  wire logic   regs_sel_i,     // cpu request level
    input  wire logic   regs_wr_i,
    input  wire addr_t  regs_addr_i,
    input  wire word_t  regs_data_i,
    output logic        regs_ack_o,
    output word_t       vram_data_o     // shared read data
);

word_t  vram_mem [256];
addr_t  mem_addr;
logic   mem_sel;
logic   mem_wr;

// fixed priority, cpu only gets idle video cycles
assign regs_ack_o = regs_sel_i & ~vgen_sel_i;
assign mem_sel    = vgen_sel_i | regs_sel_i;
assign mem_wr     = regs_ack_o & regs_wr_i;     // writes only from cpu
assign mem_addr   = vgen_sel_i ? vgen_addr_i : regs_addr_i;

always_ff @(posedge clk) begin
    if (mem_wr) begin
        vram_mem[mem_addr] <= regs_data_i;
    end
    if (mem_sel) begin
        vram_data_o <= vram_mem[mem_addr];  // old data on a write
    end
end

endmodule

// File: design/bus_reg_interface.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host side of the controller: byte-lane decode of 16-bit registers,
// vram write/read requests with auto-increment, palette writes and the
// vblank interrupt mask, status and cpu strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module bus_reg_interface import xosera_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       bus_cs_n_i,     // access strobe, active low
    input  wire logic       bus_rd_nwr_i,   // 1 = read, 0 = write
    input  wire reg_num_t   bus_reg_num_i,
    input  wire logic       bus_bytesel_i,  // 0 = even (high) byte, 1 = odd (low)
    input  wire byte_t      bus_data_i,
    output byte_t           bus_data_o,
    input  wire logic       regs_ack_i,     // vram access done this cycle
    input  wire word_t      vram_data_i,
    input  wire logic       vblank_intr_i,
    output logic            regs_sel_o,
    output logic            regs_wr_o,
    output addr_t           regs_addr_o,
    output word_t           regs_data_o,
    output logic            pal_wr_o,
    output color_t          pal_addr_o,
    output rgb_t            pal_data_o,
    output logic            bus_intr_o
);

acc_state_t acc_state;      // vram request state
byte_t      hold_hi;        // even byte waiting for its odd half
byte_t      rd_mux;         // read data before the output register
addr_t      wr_addr;
addr_t      rd_addr;
word_t      rd_buf;         // last word read from vram
logic       rd_latch;       // read data valid on vram_data_i this cycle
logic       intr_mask;
logic       intr_status;    // pending vblank
logic       bus_wr;
logic       bus_rd;
logic       wr_odd;         // odd byte write, completes a register
logic       intr_clear;

assign bus_wr     = ~bus_cs_n_i & ~bus_rd_nwr_i;
assign bus_rd     = ~bus_cs_n_i & bus_rd_nwr_i;
assign wr_odd     = bus_wr & bus_bytesel_i;
assign intr_clear = wr_odd && (bus_reg_num_i == REG_INT_CTRL) && bus_data_i[0];

assign regs_sel_o  = (acc_state != IDLE);           // held until ack
assign regs_wr_o   = (acc_state == WR_WAIT);
assign regs_addr_o = regs_wr_o ? wr_addr : rd_addr;

// register readback, odd byte is the low half
always_comb begin
    rd_mux = 8'h00;
    case (bus_reg_num_i)
        REG_INT_CTRL:   rd_mux = {7'b0, bus_bytesel_i ? intr_status : intr_mask};
        REG_WR_ADDR:    rd_mux = bus_bytesel_i ? wr_addr : 8'h00;
        REG_DATA:       rd_mux = bus_bytesel_i ? rd_buf[7:0] : rd_buf[15:8];
        REG_RD_ADDR:    rd_mux = bus_bytesel_i ? rd_addr : 8'h00;
        REG_PAL_ADDR:   rd_mux = bus_bytesel_i ? {4'h0, pal_addr_o} : 8'h00;
        default:        rd_mux = 8'h00;
    endcase
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        acc_state  <= IDLE;
        wr_addr    <= '0;
        rd_addr    <= '0;
        rd_latch   <= 1'b0;
        pal_wr_o   <= 1'b0;
        pal_addr_o <= '0;
        intr_mask  <= 1'b0;
        bus_data_o <= '0;
    end else begin
        pal_wr_o <= 1'b0;                       // single cycle strobe
        rd_latch <= 1'b0;
        if (pal_wr_o) begin
            pal_addr_o <= pal_addr_o + 1'b1;    // wraps at 16
        end

        // finish the pending vram access on ack
        case (acc_state)
            WR_WAIT: if (regs_ack_i) begin
                wr_addr   <= wr_addr + 1'b1;
                acc_state <= IDLE;
            end
            RD_WAIT: if (regs_ack_i) begin
                rd_addr   <= rd_addr + 1'b1;
                rd_latch  <= 1'b1;              // word arrives next cycle
                acc_state <= IDLE;
            end
            default: acc_state <= IDLE;
        endcase

        if (wr_odd) begin
            case (bus_reg_num_i)
                REG_WR_ADDR:    wr_addr <= bus_data_i;
                REG_DATA:       acc_state <= WR_WAIT;
                REG_RD_ADDR: begin
                    rd_addr   <= bus_data_i;
                    acc_state <= RD_WAIT;
                end
                REG_PAL_ADDR:   pal_addr_o <= bus_data_i[3:0];
                REG_PAL_DATA:   pal_wr_o <= 1'b1;
                default: ;
            endcase
        end

        if (bus_wr && !bus_bytesel_i && (bus_reg_num_i == REG_INT_CTRL)) begin
            intr_mask <= bus_data_i[0];         // mask set straight from even byte
        end
        if (bus_rd) begin
            bus_data_o <= rd_mux;               // holds until next read
        end
    end
end

// data holding registers
always_ff @(posedge clk) begin
    if (bus_wr && !bus_bytesel_i) begin
        hold_hi <= bus_data_i;
    end
    if (wr_odd && (bus_reg_num_i == REG_DATA)) begin
        regs_data_o <= {hold_hi, bus_data_i};
    end
    if (wr_odd && (bus_reg_num_i == REG_PAL_DATA)) begin
        pal_data_o <= {hold_hi[3:0], bus_data_i};   // low 12 bits only
    end
    if (rd_latch) begin
        rd_buf <= vram_data_i;
    end
end

// vblank interrupt, clear wins over a new trigger
always_ff @(posedge clk) begin
    if (reset_i) begin
        intr_status <= 1'b0;
        bus_intr_o  <= 1'b0;
    end else begin
        bus_intr_o  <= vblank_intr_i & intr_mask & ~intr_status;
        intr_status <= (intr_status | vblank_intr_i) & ~intr_clear;
    end
end

endmodule

// File: design/xosera_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, types, host register numbers and default video timing
// for the small display controller, imported by every design module
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package xosera_pkg;

typedef logic [7:0]     byte_t;         // host bus byte
typedef logic [15:0]    word_t;         // vram / register word
typedef logic [7:0]     addr_t;         // vram word address, 256 words
typedef logic [3:0]     color_t;        // palette index, one pixel
typedef logic [11:0]    rgb_t;          // {red, green, blue} 4 bits each
typedef logic [3:0]     reg_num_t;      // host register number
typedef logic [7:0]     hcount_t;       // horizontal counter
typedef logic [7:0]     vcount_t;       // vertical counter

// host register numbers
localparam reg_num_t REG_INT_CTRL   = 4'h0;     // even: mask, odd: status / clear
localparam reg_num_t REG_WR_ADDR    = 4'h1;
localparam reg_num_t REG_DATA       = 4'h2;
localparam reg_num_t REG_RD_ADDR    = 4'h3;
localparam reg_num_t REG_PAL_ADDR   = 4'h4;
localparam reg_num_t REG_PAL_DATA   = 4'h5;

// default timing, tiny mode so a frame is 960 clocks
localparam int DEF_H_VISIBLE    = 32;
localparam int DEF_H_TOTAL      = 48;
localparam int DEF_H_SYNC_START = 36;
localparam int DEF_H_SYNC_END   = 40;
localparam int DEF_V_VISIBLE    = 16;
localparam int DEF_V_TOTAL      = 20;
localparam int DEF_V_SYNC_START = 17;
localparam int DEF_V_SYNC_END   = 18;

localparam int PIX_PER_WORD         = 4;    // 4-bit pixels per vram word
localparam int WORDS_PER_LINE_SHIFT = 3;    // 8 words per line

// cpu vram access state
typedef enum logic [1:0] {
    IDLE,
    WR_WAIT,
    RD_WAIT
} acc_state_t;

endpackage
